// File: all.f
hw/lock_pkg.sv
hw/key_decoder.sv
hw/digit_buffer.sv
hw/lock_fsm.sv
hw/lockout_timer.sv
hw/buzzer_tone.sv
hw/keypad_lock_top.sv
sim/keypad_lock_tb.sv

// File: hw/buzzer_tone.sv
`timescale 1ns/1ns
`default_nettype none

module buzzer_tone import lock_pkg::*; #(
    parameter int BEEP_UNIT = 40,
    parameter int TONE_HALF = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  beep_req_t beep,
    output logic      buzzer
);

    localparam int DW       = $clog2(3 * BEEP_UNIT + 1);
    localparam int HW       = $clog2(2 * TONE_HALF + 1);
    localparam int HALF_OK  = (TONE_HALF > 1) ? TONE_HALF / 2 : 1;

    localparam logic [DW-1:0] UNIT_1 = DW'(BEEP_UNIT);
    localparam logic [DW-1:0] UNIT_2 = DW'(2 * BEEP_UNIT);
    localparam logic [DW-1:0] UNIT_3 = DW'(3 * BEEP_UNIT);

    beep_kind_t    kind_q;    // pattern being played
    logic          active;
    logic [DW-1:0] dur_cnt;   // cycles since the pattern start
    logic [DW-1:0] dur_next;
    logic [DW-1:0] dur_len;
    logic [HW-1:0] half_cnt;
    logic [HW-1:0] half_len;
    logic          quiet;     // silent middle unit of the fail tone

    assign dur_next = dur_cnt + DW'(1);

    always_comb begin
        case (kind_q)
            BEEP_OK: begin
                dur_len  = UNIT_3;
                half_len = HW'(HALF_OK);  // higher pitch
            end
            BEEP_FAIL: begin
                dur_len  = UNIT_3;
                half_len = HW'(2 * TONE_HALF);
            end
            default: begin
                dur_len  = UNIT_1;
                half_len = HW'(TONE_HALF);
            end
        endcase
    end

    assign quiet = (kind_q == BEEP_FAIL) && (dur_next >= UNIT_1) && (dur_next < UNIT_2);

    always_ff @(posedge clk) begin
        if (beep.valid) begin
            kind_q <= beep.kind;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            dur_cnt  <= '0;
            half_cnt <= '0;
            buzzer   <= 1'b0;
        end else if (beep.valid) begin
            active   <= 1'b1;  // restart on every request
            dur_cnt  <= '0;
            half_cnt <= '0;
            buzzer   <= 1'b1;
        end else if (active) begin
            dur_cnt <= dur_next;
            if (dur_next == dur_len) begin
                active <= 1'b0;
                buzzer <= 1'b0;
            end else begin
                if (half_cnt == half_len - HW'(1)) begin
                    half_cnt <= '0;
                    buzzer   <= quiet ? 1'b0 : ~buzzer;
                end else begin
                    half_cnt <= half_cnt + HW'(1);
                    if (quiet) begin
                        buzzer <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/digit_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module digit_buffer import lock_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       shift_en,
    input  logic       clear_en,
    input  digit_t     shift_digit,
    output display_t   code,
    output logic [1:0] count,
    output display_t   entry_view
);

    // held digits, newest in the right nibble
    always_ff @(posedge clk) begin
        if (shift_en && !clear_en && (count != 2'd3)) begin
            code <= {code[7:0], shift_digit};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear_en) begin
            count <= '0;               // clear wins over a shift
        end else if (shift_en && (count != 2'd3)) begin
            count <= count + 2'd1;
        end
    end

    // right-aligned view, unused places blank
    always_comb begin
        case (count)
            2'd0: begin
                entry_view = {GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK};
            end
            2'd1: begin
                entry_view = {GLYPH_BLANK, GLYPH_BLANK, code[3:0]};
            end
            2'd2: begin
                entry_view = {GLYPH_BLANK, code[7:0]};
            end
            default: begin
                entry_view = code;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hw/key_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module key_decoder import lock_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] keys,
    output key_event_t  key_event
);

    // keypad line to key code, index is the line number
    localparam key_t KEY_MAP [16] = '{
        KEY_ENTER,   // line 0
        KEY_NONE,
        KEY_NONE,
        4'd0,
        KEY_NONE,
        4'd3,
        4'd2,
        4'd1,
        KEY_CLEAR,   // line 8
        4'd6,
        4'd5,
        4'd4,
        KEY_CANCEL,  // line 12
        4'd9,
        4'd8,
        4'd7
    };

    logic [4:0] hits;     // number of lines pressed
    key_t       decoded;
    key_t       prev_key; // decoded key of the cycle before

    always_comb begin
        hits    = '0;
        decoded = KEY_NONE;
        for (int i = 0; i < 16; i++) begin
            if (keys[i]) begin
                hits    = hits + 5'd1;
                decoded = KEY_MAP[i];
            end
        end
        if (hits != 5'd1) begin
            decoded = KEY_NONE;  // nothing or several keys
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prev_key  <= KEY_NONE;
            key_event <= '{valid: 1'b0, key: KEY_NONE};
        end else begin
            prev_key        <= decoded;
            key_event.key   <= decoded;
            key_event.valid <= (decoded != prev_key) && (decoded != KEY_NONE);
        end
    end

endmodule

`default_nettype wire

// File: hw/keypad_lock_top.sv
`timescale 1ns/1ns
`default_nettype none

module keypad_lock_top import lock_pkg::*; #(
    parameter display_t PASSCODE      = 12'h246,
    parameter int       MAX_TRIES     = 4,
    parameter int       TICKS_PER_SEC = 50,
    parameter int       BEEP_UNIT     = 40,
    parameter int       TONE_HALF     = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] keys,
    output display_t    display,
    output logic [1:0]  entered,
    output logic [2:0]  tries,
    output logic        buzzer
);

    key_event_t key_event;
    beep_req_t  beep;
    logic       shift_en;
    logic       clear_en;
    digit_t     shift_digit;
    display_t   code;
    display_t   entry_view;
    bcd2_t      seconds;
    logic       run;
    logic       done;

    key_decoder key_decoder_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .keys      (keys),
        .key_event (key_event)
    );

    digit_buffer digit_buffer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .shift_en    (shift_en),
        .clear_en    (clear_en),
        .shift_digit (shift_digit),
        .code        (code),
        .count       (entered),     // digits held
        .entry_view  (entry_view)
    );

    lock_fsm #(
        .PASSCODE  (PASSCODE),
        .MAX_TRIES (MAX_TRIES)
    ) lock_fsm_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .key_event   (key_event),
        .code        (code),
        .count       (entered),
        .entry_view  (entry_view),
        .seconds     (seconds),
        .done        (done),
        .shift_en    (shift_en),
        .clear_en    (clear_en),
        .shift_digit (shift_digit),
        .run         (run),
        .beep        (beep),
        .display     (display),
        .tries       (tries)
    );

    lockout_timer #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) lockout_timer_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .run     (run),
        .seconds (seconds),
        .done    (done)
    );

    buzzer_tone #(
        .BEEP_UNIT (BEEP_UNIT),
        .TONE_HALF (TONE_HALF)
    ) buzzer_tone_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .beep   (beep),
        .buzzer (buzzer)
    );

endmodule

`default_nettype wire

// File: hw/lock_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module lock_fsm import lock_pkg::*; #(
    parameter display_t PASSCODE  = 12'h246,
    parameter int       MAX_TRIES = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  key_event_t key_event,
    input  display_t   code,
    input  logic [1:0] count,
    input  display_t   entry_view,
    input  bcd2_t      seconds,
    input  logic       done,
    output logic       shift_en,
    output logic       clear_en,
    output digit_t     shift_digit,
    output logic       run,
    output beep_req_t  beep,
    output display_t   display,
    output logic [2:0] tries
);

    localparam logic [2:0] TRY_LIMIT  = 3'(MAX_TRIES);
    localparam display_t   OPEN_VIEW  = {GLYPH_A, GLYPH_S, GLYPH_S};
    localparam display_t   BLANK_VIEW = {GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK};

    lock_state_t state;
    logic        is_digit;
    logic        is_exit;    // clear or cancel
    logic        full_enter; // enter with three digits held
    logic        code_ok;
    logic [2:0]  tries_inc;

    assign is_digit   = key_event.key <= 4'd9;
    assign is_exit    = (key_event.key == KEY_CLEAR) || (key_event.key == KEY_CANCEL);
    assign full_enter = (key_event.key == KEY_ENTER) && (count == 2'd3);
    assign code_ok    = code == PASSCODE;
    assign tries_inc  = tries + 3'd1;

    // buffer and timer steering, same cycle as the event
    assign shift_digit = key_event.key;
    assign shift_en    = key_event.valid && (state == ST_ENTRY) && is_digit;
    assign run         = state == ST_LOCKED;

    always_comb begin
        clear_en = 1'b0;
        if (key_event.valid) begin
            if (state == ST_ENTRY) begin
                clear_en = is_exit || (full_enter && !code_ok);
            end else if (state == ST_OPEN) begin
                clear_en = is_exit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_ENTRY;
            tries   <= '0;
            display <= BLANK_VIEW;
            beep    <= '{valid: 1'b0, kind: BEEP_KEY};
        end else begin
            beep.valid <= 1'b0;
            case (state)
                ST_ENTRY: begin
                    display <= entry_view;
                    if (key_event.valid) begin
                        beep <= '{valid: 1'b1, kind: BEEP_KEY};
                        if (is_digit) begin
                            if (count != 2'd3) begin
                                display <= {entry_view[7:0], key_event.key};  // view after shift
                            end
                        end else if (is_exit) begin
                            display <= BLANK_VIEW;
                            if (key_event.key == KEY_CLEAR) begin
                                tries <= '0;
                            end
                        end else if (full_enter) begin
                            if (code_ok) begin
                                state     <= ST_OPEN;
                                display   <= OPEN_VIEW;
                                beep.kind <= BEEP_OK;
                            end else begin
                                tries     <= tries_inc;
                                beep.kind <= BEEP_FAIL;
                                if (tries_inc == TRY_LIMIT) begin
                                    state   <= ST_LOCKED;
                                    display <= '0;  // seconds start at 00
                                end else begin
                                    display <= BLANK_VIEW;
                                end
                            end
                        end
                    end
                end
                ST_OPEN: begin
                    display <= OPEN_VIEW;
                    if (key_event.valid) begin
                        beep <= '{valid: 1'b1, kind: BEEP_KEY};
                        if (is_exit) begin
                            state   <= ST_ENTRY;
                            display <= BLANK_VIEW;
                        end
                    end
                end
                ST_LOCKED: begin
                    // keys ignored until the timer runs out
                    display <= {digit_t'(0), seconds};
                    if (done) begin
                        state   <= ST_ENTRY;
                        tries   <= '0;
                        display <= BLANK_VIEW;
                    end
                end
                default: begin
                    state <= ST_ENTRY;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/lock_pkg.sv
`default_nettype none

package lock_pkg;

    typedef logic [3:0]  key_t;      // 0..9 digits, then commands
    typedef logic [3:0]  digit_t;    // one bcd digit
    typedef logic [11:0] display_t;  // three nibbles, left one in [11:8]
    typedef logic [7:0]  bcd2_t;     // two bcd digits of seconds

    localparam key_t KEY_ENTER  = 4'd10;
    localparam key_t KEY_CLEAR  = 4'd11;
    localparam key_t KEY_CANCEL = 4'd12;
    localparam key_t KEY_NONE   = 4'd15;

    localparam digit_t GLYPH_A     = 4'd11;
    localparam digit_t GLYPH_S     = 4'd12;
    localparam digit_t GLYPH_BLANK = 4'd15;

    typedef enum logic [1:0] {
        BEEP_KEY,
        BEEP_OK,
        BEEP_FAIL
    } beep_kind_t;

    typedef enum logic [1:0] {
        ST_ENTRY,
        ST_OPEN,
        ST_LOCKED
    } lock_state_t;

    typedef struct packed {
        logic valid;  // one-cycle press strobe
        key_t key;
    } key_event_t;

    typedef struct packed {
        logic       valid;  // one-cycle request strobe
        beep_kind_t kind;
    } beep_req_t;

endpackage

`default_nettype wire

// File: hw/lockout_timer.sv
`timescale 1ns/1ns
`default_nettype none

module lockout_timer import lock_pkg::*; #(
    parameter int TICKS_PER_SEC = 50
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  run,
    output bcd2_t seconds,
    output logic  done
);

    localparam int TW = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
    localparam logic [TW-1:0] TICK_LAST = TW'(TICKS_PER_SEC - 1);

    logic [TW-1:0] tick_cnt;
    logic          sec_tick;  // last clock of a second
    logic          at_limit;  // seconds held at 60

    assign sec_tick = tick_cnt == TICK_LAST;
    assign at_limit = seconds == 8'h60;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            seconds  <= '0;
            done     <= 1'b0;
        end else if (!run) begin
            tick_cnt <= '0;
            seconds  <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!at_limit) begin
                if (sec_tick) begin
                    tick_cnt <= '0;
                    if (seconds == 8'h59) begin
                        seconds <= 8'h60;
                        done    <= 1'b1;
                    end else if (seconds[3:0] == 4'd9) begin
                        seconds[7:4] <= seconds[7:4] + 4'd1;  // carry into tens
                        seconds[3:0] <= 4'd0;
                    end else begin
                        seconds[3:0] <= seconds[3:0] + 4'd1;
                    end
                end else begin
                    tick_cnt <= tick_cnt + TW'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the keypad lock testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module keypad_lock_tb -f all.f || exit 1
out="$(./obj_dir/Vkeypad_lock_tb)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "All tests passed" && exit 0 || exit 1

// File: sim/keypad_lock_tb.sv
`timescale 1ns/1ns
`default_nettype none

module keypad_lock_tb import lock_pkg::*; ();

    localparam display_t BLANK_ALL = {GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK};
    localparam display_t OPEN_ALL  = {GLYPH_A, GLYPH_S, GLYPH_S};

    logic        clk;
    logic        rst_n;
    logic [15:0] keys;
    display_t    display;
    logic [1:0]  entered;
    logic [2:0]  tries;
    logic        buzzer;

    int errors;
    int checks;
    int timeouts;
    int wrong [3];  // last random wrong code

    // stimulus table: keypad word and expected outputs after the release
    logic [15:0] row_keys  [$];
    display_t    row_disp  [$];
    logic [1:0]  row_ent   [$];
    logic [2:0]  row_tries [$];

    keypad_lock_top #(
        .PASSCODE      (12'h246),
        .MAX_TRIES     (4),
        .TICKS_PER_SEC (4),
        .BEEP_UNIT     (40),
        .TONE_HALF     (4)
    ) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .keys    (keys),
        .display (display),
        .entered (entered),
        .tries   (tries),
        .buzzer  (buzzer)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // keypad line of each key
    function automatic logic [15:0] key_word(input key_t k);
        int line;
        case (k)
            4'd0: line = 3;
            4'd1: line = 7;
            4'd2: line = 6;
            4'd3: line = 5;
            4'd4: line = 11;
            4'd5: line = 10;
            4'd6: line = 9;
            4'd7: line = 15;
            4'd8: line = 14;
            4'd9: line = 13;
            KEY_ENTER: line = 0;
            KEY_CLEAR: line = 8;
            KEY_CANCEL: line = 12;
            default: line = -1;
        endcase
        if (line < 0) begin
            return '0;
        end
        return 16'd1 << line;
    endfunction

    // next lockout display, seconds in bcd
    function automatic display_t bcd_next(input display_t v);
        logic [3:0] tens;
        logic [3:0] units;
        tens  = v[7:4];
        units = v[3:0];
        if (units == 4'd9) begin
            units = 4'd0;
            tens  = tens + 4'd1;
        end else begin
            units = units + 4'd1;
        end
        return {4'd0, tens, units};
    endfunction

    task automatic next_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
        end
        #10;  // inputs move just after the edge
    endtask

    task automatic report_mismatch(input string msg);
        errors++;
        $display("MISMATCH at %0t ns: %s", $time, msg);
    endtask

    task automatic check_outputs(input display_t exp_disp, input logic [1:0] exp_ent,
                                 input logic [2:0] exp_tries);
        checks += 3;
        if (display !== exp_disp) begin
            report_mismatch($sformatf("display %h, expected %h", display, exp_disp));
        end
        if (entered !== exp_ent) begin
            report_mismatch($sformatf("entered %0d, expected %0d", entered, exp_ent));
        end
        if (tries !== exp_tries) begin
            report_mismatch($sformatf("tries %0d, expected %0d", tries, exp_tries));
        end
    endtask

    task automatic add_row(input logic [15:0] w, input display_t d, input logic [1:0] e,
                           input logic [2:0] t);
        row_keys.push_back(w);
        row_disp.push_back(d);
        row_ent.push_back(e);
        row_tries.push_back(t);
    endtask

    // three random digits, never the stored code
    task automatic add_wrong_digits(input logic [2:0] t);
        digit_t d0;
        digit_t d1;
        digit_t d2;
        do begin
            for (int i = 0; i < 3; i++) begin
                wrong[i] = int'($urandom % 32'd10);
            end
        end while (wrong[0] == 2 && wrong[1] == 4 && wrong[2] == 6);
        d0 = 4'(wrong[0]);
        d1 = 4'(wrong[1]);
        d2 = 4'(wrong[2]);
        add_row(key_word(d0), {GLYPH_BLANK, GLYPH_BLANK, d0}, 2'd1, t);
        add_row(key_word(d1), {GLYPH_BLANK, d0, d1}, 2'd2, t);
        add_row(key_word(d2), {d0, d1, d2}, 2'd3, t);
    endtask

    task automatic run_table();
        for (int i = 0; i < row_keys.size(); i++) begin
            keys = row_keys[i];
            next_cycles(3);  // hold
            keys = '0;
            next_cycles(3);  // release
            check_outputs(row_disp[i], row_ent[i], row_tries[i]);
        end
        row_keys.delete();
        row_disp.delete();
        row_ent.delete();
        row_tries.delete();
    endtask

    // cycle c is sampled after edge c+1 from the key change
    task automatic press_and_listen(input key_t k, input int ncyc, output int toggles,
                                    output logic high_mid, output logic high_late);
        logic last;
        toggles   = 0;
        high_mid  = 1'b0;
        high_late = 1'b0;
        last      = buzzer;
        keys      = key_word(k);
        for (int c = 0; c < ncyc; c++) begin
            next_cycles(1);
            if (c == 2) begin
                keys = '0;
            end
            if (c <= 40 && buzzer !== last) begin
                toggles++;
            end
            if (c >= 42 && c <= 78 && buzzer !== 1'b0) begin
                high_mid = 1'b1;
            end
            if ((c >= 45 && k <= 4'd9 && buzzer !== 1'b0) || (c > 78 && buzzer === 1'b1)) begin
                high_late = 1'b1;
            end
            last = buzzer;
        end
    endtask

    task automatic lockout_run();
        int       lock_cycles;
        logic     ended;
        logic     saw_ten;
        display_t prev;
        keys = key_word(KEY_ENTER);  // fourth wrong code
        next_cycles(2);
        keys = '0;
        check_outputs(12'h000, 2'd0, 3'd4);
        keys = key_word(4'd5);       // ignored while locked
        next_cycles(3);
        keys = '0;
        next_cycles(3);
        lock_cycles = 6;
        if (entered !== 2'd0 || display[11:8] !== 4'd0) begin
            report_mismatch($sformatf("key taken in lockout, display %h", display));
        end
        prev    = display;
        ended   = 1'b0;
        saw_ten = 1'b0;
        while (!ended && lock_cycles < 400) begin
            next_cycles(1);
            lock_cycles++;
            if (display !== prev) begin
                if (display === BLANK_ALL) begin
                    ended = 1'b1;
                end else if (display !== bcd_next(prev)) begin
                    report_mismatch($sformatf("seconds %h after %h", display, prev));
                end else if (prev == 12'h009) begin
                    saw_ten = 1'b1;
                end
                prev = display;
            end
        end
        if (!ended) begin
            timeouts++;
            $display("Timeout: the lockout did not end within 400 cycles");
            return;
        end
        if (!saw_ten) begin
            report_mismatch("seconds never stepped from 09 to 10");
        end
        if (lock_cycles < 236 || lock_cycles > 244) begin
            report_mismatch($sformatf("lockout lasted %0d cycles", lock_cycles));
        end
        check_outputs(BLANK_ALL, 2'd0, 3'd0);
    endtask

    initial begin
        int   toggles;
        logic high_mid;
        logic high_late;
        errors   = 0;
        checks   = 0;
        timeouts = 0;
        void'($urandom(32'h08f39614));
        rst_n = 1'b0;
        keys  = '0;
        repeat (8) begin
            @(posedge clk);
        end
        #10;
        rst_n = 1'b1;
        check_outputs(BLANK_ALL, 2'd0, 3'd0);
        if (buzzer !== 1'b0) begin
            report_mismatch("buzzer high after reset");
        end

        add_row(key_word(4'd1), 12'hFF1, 2'd1, 3'd0);
        add_row(key_word(4'd3), 12'hF13, 2'd2, 3'd0);
        add_row(key_word(4'd5), 12'h135, 2'd3, 3'd0);
        add_row(key_word(4'd7), 12'h135, 2'd3, 3'd0);  // fourth digit dropped
        add_row(key_word(KEY_CANCEL), BLANK_ALL, 2'd0, 3'd0);
        add_row(key_word(4'd2), 12'hFF2, 2'd1, 3'd0);
        add_row(key_word(4'd4), 12'hF24, 2'd2, 3'd0);
        add_row(key_word(4'd6), 12'h246, 2'd3, 3'd0);
        add_row(key_word(KEY_ENTER), OPEN_ALL, 2'd3, 3'd0);
        add_row(key_word(KEY_CANCEL), BLANK_ALL, 2'd0, 3'd0);
        add_wrong_digits(3'd0);
        add_row(key_word(KEY_ENTER), BLANK_ALL, 2'd0, 3'd1);
        add_row(key_word(4'd1), 12'hFF1, 2'd1, 3'd1);
        add_row(key_word(4'd2), 12'hF12, 2'd2, 3'd1);
        add_row(key_word(KEY_ENTER), 12'hF12, 2'd2, 3'd1);  // too few digits
        add_row(key_word(KEY_CANCEL), BLANK_ALL, 2'd0, 3'd1);
        add_wrong_digits(3'd1);
        add_row(key_word(KEY_ENTER), BLANK_ALL, 2'd0, 3'd2);
        add_row(key_word(KEY_CLEAR), BLANK_ALL, 2'd0, 3'd0);
        run_table();

        next_cycles(50);  // let the last beep die out
        if (buzzer !== 1'b0) begin
            report_mismatch("buzzer still high after the key beep");
        end
        press_and_listen(4'd8, 60, toggles, high_mid, high_late);
        if (toggles < 2 || high_late) begin
            report_mismatch($sformatf("key beep had %0d toggles, late high %0b",
                                      toggles, high_late));
        end
        add_row(key_word(KEY_CANCEL), BLANK_ALL, 2'd0, 3'd0);
        add_wrong_digits(3'd0);
        run_table();
        press_and_listen(KEY_ENTER, 125, toggles, high_mid, high_late);
        if (high_mid || !high_late) begin
            report_mismatch($sformatf("fail tone high in middle %0b, after %0b",
                                      high_mid, high_late));
        end
        check_outputs(BLANK_ALL, 2'd0, 3'd1);

        add_row(key_word(KEY_CLEAR), BLANK_ALL, 2'd0, 3'd0);
        for (int t = 0; t < 3; t++) begin
            add_wrong_digits(3'(t));
            add_row(key_word(KEY_ENTER), BLANK_ALL, 2'd0, 3'(t + 1));
        end
        add_wrong_digits(3'd3);
        run_table();
        lockout_run();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
